/* compile.f */
+incdir+hdl
hdl/memsys_types_pkg.sv
hdl/memsys_bus_pkg.sv
hdl/cache_mem_if.sv
hdl/iomem_if.sv
hdl/icache_fetch.sv
hdl/dcache_access.sv
hdl/memory_arbiter.sv
hdl/block_ram.sv
hdl/memsys_top.sv
tb/memsys_tb.sv

/* Bender.yml */
package:
  name: memsys

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/memsys_types_pkg.sv
      - hdl/memsys_bus_pkg.sv
      - hdl/cache_mem_if.sv
      - hdl/iomem_if.sv
      - hdl/icache_fetch.sv
      - hdl/dcache_access.sv
      - hdl/memory_arbiter.sv
      - hdl/block_ram.sv
      - hdl/memsys_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/memsys_tb.sv

/* tb/memsys_tb.sv */
/*
  Testbench of the memory subsystem.
  Drives the fetch and data ports, tracks every store in a byte-array model
  and compares each valid pulse with the value the model predicts.
*/
`default_nettype none
`include "memsys_config.svh"

module memsys_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // Operations per test, used to size the watchdog.
  localparam int OPS_LANES  = 115;
  localparam int OPS_FETCH  = 7;
  localparam int OPS_ARB    = 4;
  localparam int OPS_RANDOM = 232;
  localparam int OP_COUNT   = OPS_LANES + OPS_FETCH + OPS_ARB + OPS_RANDOM + 4;
  localparam int WATCHDOG_NS = OP_COUNT * (2 * `MEMSYS_MEM_LATENCY + 8) * 10;
  localparam int WAIT_LIMIT = 100;
  localparam int unsigned LCG_SEED = 63932;

  typedef struct packed {
    logic                     we;
    memsys_bus_pkg::size_e    size;
    memsys_types_pkg::addr_t  addr;
    memsys_types_pkg::word_t  wdata;
  } data_op_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     fetch_req_i;
  memsys_types_pkg::addr_t  fetch_addr_i;
  logic                     fetch_valid_o;
  memsys_types_pkg::word_t  fetch_instr_o;
  logic                     data_req_i;
  logic                     data_we_i;
  memsys_bus_pkg::size_e    data_size_i;
  memsys_types_pkg::addr_t  data_addr_i;
  memsys_types_pkg::word_t  data_wdata_i;
  logic                     data_valid_o;
  memsys_types_pkg::word_t  data_rdata_o;

  // Byte-wide image of the 4 KiB memory, little-endian like the RAM lanes.
  logic [7:0]               model_mem [4096];
  memsys_types_pkg::word_t  fetch_exp_q [$];
  memsys_types_pkg::word_t  data_exp_q [$];
  memsys_types_pkg::word_t  fetch_exp;
  memsys_types_pkg::word_t  data_exp;
  int unsigned              lcg_state;
  int                       errors;
  int                       tests_ok;
  int                       tests_bad;

  memsys_top memsys_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_instr_o (fetch_instr_o),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_size_i   (data_size_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_valid_o  (data_valid_o),
    .data_rdata_o  (data_rdata_o)
  );

  always #5 clk_i = ~clk_i;

  // Next value of the linear congruential sequence.
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int size_bytes(memsys_bus_pkg::size_e s);
    case (s)
      memsys_bus_pkg::SIZE_BYTE: return 1;
      memsys_bus_pkg::SIZE_HALF: return 2;
      default:                   return 4;
    endcase
  endfunction

  // Expected load or fetch result. Narrow loads are zero-extended.
  function automatic memsys_types_pkg::word_t ref_load(memsys_types_pkg::addr_t a,
      memsys_bus_pkg::size_e s);
    logic [11:0] b;
    b = a[11:0];
    case (s)
      memsys_bus_pkg::SIZE_BYTE: return {24'b0, model_mem[b]};
      memsys_bus_pkg::SIZE_HALF: return {16'b0, model_mem[b + 12'd1], model_mem[b]};
      default: return {model_mem[b + 12'd3], model_mem[b + 12'd2],
                       model_mem[b + 12'd1], model_mem[b]};
    endcase
  endfunction

  task automatic model_store(input memsys_types_pkg::addr_t a,
      input memsys_bus_pkg::size_e s, input memsys_types_pkg::word_t d);
    for (int i = 0; i < size_bytes(s); i++) begin
      model_mem[a[11:0] + i] = d[8*i +: 8];
    end
  endtask

  // One fetch; returns the number of cycles from request to valid pulse.
  task automatic fetch_word(input memsys_types_pkg::addr_t a, output int cycles);
    fetch_exp_q.push_back(ref_load(a, memsys_bus_pkg::SIZE_WORD));
    @(posedge clk_i);
    #1;
    fetch_req_i  = 1'b1;
    fetch_addr_i = a;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      fetch_req_i = 1'b0;
      cycles++;
      @(negedge clk_i);
    end while (fetch_valid_o !== 1'b1 && cycles < WAIT_LIMIT);
    if (fetch_valid_o !== 1'b1) begin
      $display("fetch of address %h never got a fetch_valid_o pulse", a);
      errors++;
    end
  endtask

  // One load or store; the model sees a store as soon as it is issued.
  task automatic data_access(input logic we, input memsys_bus_pkg::size_e s,
      input memsys_types_pkg::addr_t a, input memsys_types_pkg::word_t d);
    int cycles;
    data_exp_q.push_back(we ? 32'h0 : ref_load(a, s));
    if (we) model_store(a, s, d);
    @(posedge clk_i);
    #1;
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_size_i  = s;
    data_addr_i  = a;
    data_wdata_i = d;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      data_req_i = 1'b0;
      cycles++;
      @(negedge clk_i);
    end while (data_valid_o !== 1'b1 && cycles < WAIT_LIMIT);
    if (data_valid_o !== 1'b1) begin
      $display("data access to address %h never got a data_valid_o pulse", a);
      errors++;
    end
  endtask

  task automatic check_idle();
    @(negedge clk_i);
    assert (fetch_valid_o === 1'b0) else begin
      $display("CHECK FAILED fetch_valid_o expected %h got %h", 1'b0, fetch_valid_o);
      errors++;
    end
    assert (data_valid_o === 1'b0) else begin
      $display("CHECK FAILED data_valid_o expected %h got %h", 1'b0, data_valid_o);
      errors++;
    end
  endtask

  // Lets the last pulse reach the checker before the test is scored.
  task automatic finish_test(input string name, input int errs_before);
    repeat (2) @(posedge clk_i);
    if (errors == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk_i) begin
    if (fetch_valid_o === 1'b1) begin
      if (fetch_exp_q.size() == 0) begin
        $display("fetch_valid_o pulsed with no fetch outstanding");
        errors++;
      end else begin
        fetch_exp = fetch_exp_q.pop_front();
        assert (fetch_instr_o === fetch_exp) else begin
          $display("CHECK FAILED fetch_instr_o expected %h got %h", fetch_exp, fetch_instr_o);
          errors++;
        end
      end
    end
    if (data_valid_o === 1'b1) begin
      if (data_exp_q.size() == 0) begin
        $display("data_valid_o pulsed with no data access outstanding");
        errors++;
      end else begin
        data_exp = data_exp_q.pop_front();
        assert (data_rdata_o === data_exp) else begin
          $display("CHECK FAILED data_rdata_o expected %h got %h", data_exp, data_rdata_o);
          errors++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    memsys_bus_pkg::size_e sizes [3];
    data_op_t              data_ops [$];
    memsys_types_pkg::addr_t fetch_ops [$];
    data_op_t              op;
    int                    errs_before;
    int                    cycles;
    int                    cycles_rand;
    int                    kind;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_size_i  = memsys_bus_pkg::SIZE_NONE;
    data_addr_i  = '0;
    data_wdata_i = '0;
    lcg_state    = LCG_SEED;
    errors       = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    sizes = '{memsys_bus_pkg::SIZE_BYTE, memsys_bus_pkg::SIZE_HALF, memsys_bus_pkg::SIZE_WORD};
    for (int i = 0; i < 4096; i++) model_mem[i] = 8'h00;

    // Test 1 watches both valid outputs through reset and a few idle cycles.
    // The outputs only take their reset value at the first clock edge.
    errs_before = errors;
    @(posedge clk_i);
    repeat (7) check_idle();
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (4) check_idle();
    finish_test("1 reset quiet", errs_before);

    // Test 2 stores each size at every aligned offset and reads back with every load size.
    errs_before = errors;
    for (int p = 0; p < 3; p++) begin
      for (int o = 0; o < 16; o += size_bytes(sizes[p])) begin
        data_access(1'b1, sizes[p], 32'h040 + o, lcg_next());
      end
      // A load of another tag on the same line makes the loads below refill from the RAM.
      data_access(1'b0, memsys_bus_pkg::SIZE_WORD, 32'h0c0, 32'h0);
      for (int q = 0; q < 3; q++) begin
        for (int o = 0; o < 16; o += size_bytes(sizes[q])) begin
          data_access(1'b0, sizes[q], 32'h040 + o, 32'h0);
        end
      end
    end
    finish_test("2 byte lanes and masks", errs_before);

    // Test 3 fetches a zero line, then a line stored before its fill, then hits on it.
    errs_before = errors;
    fetch_word(32'h124, cycles);
    for (int w = 0; w < 4; w++) begin
      data_access(1'b1, memsys_bus_pkg::SIZE_WORD, 32'h150 + 4*w, lcg_next());
    end
    fetch_word(32'h158, cycles);
    fetch_word(32'h158, cycles);
    assert (cycles == 1) else begin
      $display("fetch hit answered after %0d cycles instead of 1", cycles);
      errors++;
    end
    finish_test("3 fetch fill and hit", errs_before);

    // Test 4 lets a fetch miss and a load miss race for the arbiter.
    errs_before = errors;
    data_access(1'b1, memsys_bus_pkg::SIZE_WORD, 32'h0a8, lcg_next());
    data_access(1'b1, memsys_bus_pkg::SIZE_WORD, 32'h0c4, lcg_next());
    fork
      fetch_word(32'h0a8, cycles);
      data_access(1'b0, memsys_bus_pkg::SIZE_WORD, 32'h0c4, 32'h0);
    join
    finish_test("4 concurrent misses", errs_before);

    // Lines 0x200 to 0x27f hold code and take no stores after this fill.
    errs_before = errors;
    for (int w = 0; w < 32; w++) begin
      data_access(1'b1, memsys_bus_pkg::SIZE_WORD, 32'h200 + 4*w, lcg_next());
    end
    for (int n = 0; n < 200; n++) begin
      kind = (lcg_next() >> 8) % 3;
      if (kind == 2) begin
        fetch_ops.push_back(32'h200 + (((lcg_next() >> 8) % 32'h80) & ~32'h3));
      end else begin
        op.we    = (kind == 0);
        op.size  = sizes[(lcg_next() >> 8) % 3];
        op.wdata = lcg_next();
        if (op.we) begin
          op.addr = 32'h280 + (((lcg_next() >> 8) % 32'h180) & ~(size_bytes(op.size) - 1));
        end else begin
          op.addr = 32'h200 + (((lcg_next() >> 8) % 32'h200) & ~(size_bytes(op.size) - 1));
        end
        data_ops.push_back(op);
      end
    end
    fork
      begin
        foreach (data_ops[k]) data_access(data_ops[k].we, data_ops[k].size, data_ops[k].addr,
            data_ops[k].wdata);
      end
      begin
        foreach (fetch_ops[k]) fetch_word(fetch_ops[k], cycles_rand);
      end
    join
    finish_test("5 random mixed traffic", errs_before);

    if (fetch_exp_q.size() != 0 || data_exp_q.size() != 0) begin
      $display("some requests ended without a response");
      errors++;
    end
    $display("summary: %0d tests ok, %0d tests failing, %0d check errors",
             tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/memsys_top.sv */
/*
  Memory subsystem top level.
  Instruction and data caches share the block RAM through the memory arbiter.
*/
`default_nettype none

module memsys_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     fetch_req_i,
  input  wire memsys_types_pkg::addr_t  fetch_addr_i,
  output      logic                     fetch_valid_o,
  output      memsys_types_pkg::word_t  fetch_instr_o,
  input  wire logic                     data_req_i,
  input  wire logic                     data_we_i,
  input  wire memsys_bus_pkg::size_e    data_size_i,
  input  wire memsys_types_pkg::addr_t  data_addr_i,
  input  wire memsys_types_pkg::word_t  data_wdata_i,
  output      logic                     data_valid_o,
  output      memsys_types_pkg::word_t  data_rdata_o
);

  cache_mem_if icache_bus ();
  cache_mem_if dcache_bus ();
  iomem_if     iomem_bus ();

  icache_fetch icache_fetch_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_instr_o (fetch_instr_o),
    .mem_o         (icache_bus.cache)
  );

  dcache_access dcache_access_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req_i),
    .data_we_i    (data_we_i),
    .data_size_i  (data_size_i),
    .data_addr_i  (data_addr_i),
    .data_wdata_i (data_wdata_i),
    .data_valid_o (data_valid_o),
    .data_rdata_o (data_rdata_o),
    .mem_o        (dcache_bus.cache)
  );

  memory_arbiter memory_arbiter_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .icache_i (icache_bus.arbiter),
    .dcache_i (dcache_bus.arbiter),
    .iomem_o  (iomem_bus.arbiter)
  );

  block_ram block_ram_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mem_i  (iomem_bus.memory)
  );

endmodule

`default_nettype wire

/* hdl/block_ram.sv */
/*
  Backing block RAM.
  Answers each accepted request after a fixed latency and applies masked byte writes
  in the response cycle.
*/
`default_nettype none
`include "memsys_config.svh"

module block_ram (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  iomem_if.memory    mem_i
);

  localparam int unsigned IDX_W = $clog2(`MEMSYS_MEM_BLOCKS);
  localparam int unsigned CNT_W = $clog2(`MEMSYS_MEM_LATENCY + 1);
  localparam int unsigned OFF_W = memsys_types_pkg::OFF_BITS;

  // Contents start out as zero.
  memsys_types_pkg::blk_t mem_q [`MEMSYS_MEM_BLOCKS] = '{default: '0};

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [IDX_W-1:0] idx;

  assign idx = mem_i.addr[OFF_W +: IDX_W];

  // The read shows the block before this cycle's write lands.
  assign mem_i.res_valid = busy_q && (cnt_q == '0);
  assign mem_i.rdata     = mem_q[idx];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q && mem_i.valid) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(`MEMSYS_MEM_LATENCY - 1);
    end else if (busy_q) begin
      if (cnt_q == '0) busy_q <= 1'b0;
      else cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_i.res_valid) begin
      for (int b = 0; b < `MEMSYS_BLK_BITS / 8; b++) begin
        if (mem_i.wmask[b]) mem_q[idx][8*b +: 8] <= mem_i.wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/memory_arbiter.sv */
/*
  Memory arbiter.
  Holds the request pulses of both caches, alternates access to the block RAM,
  builds the byte write mask and returns each response to its cache.
*/
`default_nettype none
`include "memsys_config.svh"

module memory_arbiter (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  cache_mem_if.arbiter   icache_i,
  cache_mem_if.arbiter   dcache_i,
  iomem_if.arbiter       iomem_o
);

  localparam int unsigned OFF_BITS = memsys_types_pkg::OFF_BITS;

  // Index 0 is the instruction cache, index 1 the data cache.
  logic [1:0]               req_v;
  memsys_types_pkg::addr_t  req_a [2];
  memsys_bus_pkg::size_e    req_s [2];
  memsys_types_pkg::blk_t   req_w [2];

  logic [1:0]               hold_v_q;
  memsys_types_pkg::addr_t  hold_a_q [2];
  memsys_bus_pkg::size_e    hold_s_q [2];
  memsys_types_pkg::blk_t   hold_w_q [2];

  memsys_bus_pkg::grant_e   grant_q;
  logic                     sel;
  logic [1:0]               done;
  logic [OFF_BITS-1:0]      off;

  always_comb begin
    req_v    = {dcache_i.req_valid, icache_i.req_valid};
    req_a[0] = icache_i.req_addr;
    req_a[1] = dcache_i.req_addr;
    req_s[0] = icache_i.req_size;
    req_s[1] = dcache_i.req_size;
    req_w[0] = icache_i.req_wdata;
    req_w[1] = dcache_i.req_wdata;
  end

  // The granted holding register drives memory until its response.
  assign sel = (grant_q == memsys_bus_pkg::GRANT_DCACHE);
  assign off = hold_a_q[sel][OFF_BITS-1:0];

  always_comb begin
    iomem_o.valid = (grant_q != memsys_bus_pkg::GRANT_IDLE) && hold_v_q[sel];
    iomem_o.addr  = hold_a_q[sel];
    iomem_o.wdata = hold_w_q[sel];
    // Reads carry an empty mask, stores enable one, two or four bytes.
    case (hold_s_q[sel])
      memsys_bus_pkg::SIZE_BYTE: iomem_o.wmask = memsys_types_pkg::bmask_t'(4'h1) << off;
      memsys_bus_pkg::SIZE_HALF: iomem_o.wmask = memsys_types_pkg::bmask_t'(4'h3) << off;
      memsys_bus_pkg::SIZE_WORD: iomem_o.wmask = memsys_types_pkg::bmask_t'(4'hf) << off;
      default:                   iomem_o.wmask = '0;
    endcase
  end

  // The response pulse goes straight back to the owner of the grant.
  assign done[0] = (grant_q == memsys_bus_pkg::GRANT_ICACHE) && iomem_o.res_valid;
  assign done[1] = (grant_q == memsys_bus_pkg::GRANT_DCACHE) && iomem_o.res_valid;

  assign icache_i.res_valid = done[0];
  assign icache_i.res_blk   = iomem_o.rdata;
  assign dcache_i.res_valid = done[1];
  assign dcache_i.res_blk   = iomem_o.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hold_v_q <= '0;
      grant_q  <= memsys_bus_pkg::GRANT_IDLE;
    end else begin
      for (int i = 0; i < 2; i++) begin
        // A finished slot is free again in the same edge.
        if (req_v[i] && (!hold_v_q[i] || done[i])) hold_v_q[i] <= 1'b1;
        else if (done[i]) hold_v_q[i] <= 1'b0;
      end
      case (grant_q)
        memsys_bus_pkg::GRANT_IDLE: begin
          // The instruction side wins a tie.
          if (hold_v_q[0]) grant_q <= memsys_bus_pkg::GRANT_ICACHE;
          else if (hold_v_q[1]) grant_q <= memsys_bus_pkg::GRANT_DCACHE;
        end
        memsys_bus_pkg::GRANT_ICACHE: begin
          if (done[0]) begin
            if (hold_v_q[1]) grant_q <= memsys_bus_pkg::GRANT_DCACHE;
            else if (req_v[0]) grant_q <= memsys_bus_pkg::GRANT_ICACHE;
            else grant_q <= memsys_bus_pkg::GRANT_IDLE;
          end
        end
        memsys_bus_pkg::GRANT_DCACHE: begin
          if (done[1]) begin
            if (hold_v_q[0]) grant_q <= memsys_bus_pkg::GRANT_ICACHE;
            else if (req_v[1]) grant_q <= memsys_bus_pkg::GRANT_DCACHE;
            else grant_q <= memsys_bus_pkg::GRANT_IDLE;
          end
        end
        default: grant_q <= memsys_bus_pkg::GRANT_IDLE;
      endcase
    end
  end

  // Request payload is captured together with its valid bit.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (req_v[i] && (!hold_v_q[i] || done[i])) begin
        hold_a_q[i] <= req_a[i];
        hold_s_q[i] <= req_s[i];
        hold_w_q[i] <= req_w[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/dcache_access.sv */
/*
  Data cache.
  Direct-mapped and write-through. Read misses allocate a line, stores always go to
  memory and update the line only when they hit.
*/
`default_nettype none
`include "memsys_config.svh"

module dcache_access (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     data_req_i,
  input  wire logic                     data_we_i,
  input  wire memsys_bus_pkg::size_e    data_size_i,
  input  wire memsys_types_pkg::addr_t  data_addr_i,
  input  wire memsys_types_pkg::word_t  data_wdata_i,
  output      logic                     data_valid_o,
  output      memsys_types_pkg::word_t  data_rdata_o,
  cache_mem_if.cache                    mem_o
);

  logic [`MEMSYS_LINES-1:0]     valid_q;
  memsys_types_pkg::tag_t       tags_q   [`MEMSYS_LINES];
  memsys_types_pkg::blk_t       blocks_q [`MEMSYS_LINES];
  memsys_bus_pkg::cache_state_e state_q;
  memsys_types_pkg::addr_t      addr_q;
  logic                         we_q;
  memsys_bus_pkg::size_e        size_q;
  memsys_types_pkg::blk_t       lane_q;
  logic                         req_valid_q;

  memsys_types_pkg::addr_t      look_addr;
  memsys_types_pkg::line_idx_t  idx;
  memsys_types_pkg::tag_t       tag;
  logic                         hit;
  memsys_types_pkg::blk_t       lane;

  // Picks the addressed item out of a block and zero-extends it to a word.
  function automatic memsys_types_pkg::word_t load_value(memsys_types_pkg::blk_t blk,
      memsys_types_pkg::addr_t a, memsys_bus_pkg::size_e s);
    memsys_types_pkg::word_t w;
    w = blk[{a[memsys_types_pkg::OFF_BITS-1:2], 5'b0} +: 32];
    case (s)
      memsys_bus_pkg::SIZE_BYTE: return {24'b0, w[{a[1:0], 3'b0} +: 8]};
      memsys_bus_pkg::SIZE_HALF: return {16'b0, w[{a[1], 4'b0} +: 16]};
      default:                   return w;
    endcase
  endfunction

  // Copies the stored bytes from their lanes into the cached block.
  function automatic memsys_types_pkg::blk_t store_merge(memsys_types_pkg::blk_t old_blk,
      memsys_types_pkg::blk_t lane_blk, memsys_types_pkg::addr_t a, memsys_bus_pkg::size_e s);
    memsys_types_pkg::blk_t merged;
    logic [memsys_types_pkg::OFF_BITS+2:0] base;
    merged = old_blk;
    base   = {a[memsys_types_pkg::OFF_BITS-1:0], 3'b0};
    case (s)
      memsys_bus_pkg::SIZE_BYTE: merged[base +: 8]  = lane_blk[base +: 8];
      memsys_bus_pkg::SIZE_HALF: merged[base +: 16] = lane_blk[base +: 16];
      memsys_bus_pkg::SIZE_WORD: merged[base +: 32] = lane_blk[base +: 32];
      default:                   merged = old_blk;
    endcase
    return merged;
  endfunction

  // The pending request owns the lookup until memory answers.
  assign look_addr = (state_q == memsys_bus_pkg::CACHE_READY) ? data_addr_i : addr_q;
  assign idx = look_addr[memsys_types_pkg::OFF_BITS +: memsys_types_pkg::IDX_BITS];
  assign tag = look_addr[31 -: memsys_types_pkg::TAG_BITS];
  assign hit = valid_q[idx] && (tags_q[idx] == tag);

  // Store data is replicated so that every lane carries it.
  always_comb begin
    case (data_size_i)
      memsys_bus_pkg::SIZE_BYTE: lane = {(`MEMSYS_BLK_BITS/8){data_wdata_i[7:0]}};
      memsys_bus_pkg::SIZE_HALF: lane = {(`MEMSYS_BLK_BITS/16){data_wdata_i[15:0]}};
      default:                   lane = {(`MEMSYS_BLK_BITS/32){data_wdata_i}};
    endcase
  end

  assign mem_o.req_valid = req_valid_q;
  assign mem_o.req_addr  = addr_q;
  assign mem_o.req_size  = we_q ? size_q : memsys_bus_pkg::SIZE_NONE;
  assign mem_o.req_wdata = lane_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= memsys_bus_pkg::CACHE_READY;
      valid_q      <= '0;
      req_valid_q  <= 1'b0;
      data_valid_o <= 1'b0;
    end else begin
      req_valid_q  <= 1'b0;
      data_valid_o <= 1'b0;
      case (state_q)
        memsys_bus_pkg::CACHE_READY: begin
          // Only a load hit answers at once; stores and misses go to memory.
          if (data_req_i) begin
            if (!data_we_i && hit) begin
              data_valid_o <= 1'b1;
            end else begin
              req_valid_q <= 1'b1;
              state_q     <= memsys_bus_pkg::CACHE_REFILL;
            end
          end
        end
        default: begin
          if (mem_o.res_valid) begin
            if (!we_q) valid_q[idx] <= 1'b1;
            data_valid_o <= 1'b1;
            state_q      <= memsys_bus_pkg::CACHE_READY;
          end
        end
      endcase
    end
  end

  // Arrays and payload registers.
  always_ff @(posedge clk_i) begin
    if (state_q == memsys_bus_pkg::CACHE_READY && data_req_i) begin
      addr_q       <= data_addr_i;
      we_q         <= data_we_i;
      size_q       <= data_size_i;
      lane_q       <= lane;
      data_rdata_o <= load_value(blocks_q[idx], data_addr_i, data_size_i);
    end
    if (state_q == memsys_bus_pkg::CACHE_REFILL && mem_o.res_valid) begin
      if (!we_q) begin
        blocks_q[idx] <= mem_o.res_blk;
        tags_q[idx]   <= tag;
        data_rdata_o  <= load_value(mem_o.res_blk, addr_q, size_q);
      end else begin
        // A store miss leaves the arrays alone.
        if (hit) blocks_q[idx] <= store_merge(blocks_q[idx], lane_q, addr_q, size_q);
        data_rdata_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/icache_fetch.sv */
/*
  Instruction cache.
  Direct-mapped and read-only; serves 32-bit fetches and fills whole blocks on a miss.
*/
`default_nettype none
`include "memsys_config.svh"

module icache_fetch (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     fetch_req_i,
  input  wire memsys_types_pkg::addr_t  fetch_addr_i,
  output      logic                     fetch_valid_o,
  output      memsys_types_pkg::word_t  fetch_instr_o,
  cache_mem_if.cache                    mem_o
);

  logic [`MEMSYS_LINES-1:0]    valid_q;
  memsys_types_pkg::tag_t      tags_q   [`MEMSYS_LINES];
  memsys_types_pkg::blk_t      blocks_q [`MEMSYS_LINES];
  memsys_bus_pkg::cache_state_e state_q;
  memsys_types_pkg::addr_t     miss_addr_q;
  logic                        req_valid_q;

  memsys_types_pkg::addr_t     look_addr;
  memsys_types_pkg::line_idx_t idx;
  memsys_types_pkg::tag_t      tag;
  logic                        hit;

  // While a refill is pending the arrays are indexed by the missed address.
  assign look_addr = (state_q == memsys_bus_pkg::CACHE_READY) ? fetch_addr_i : miss_addr_q;
  assign idx = look_addr[memsys_types_pkg::OFF_BITS +: memsys_types_pkg::IDX_BITS];
  assign tag = look_addr[31 -: memsys_types_pkg::TAG_BITS];
  assign hit = valid_q[idx] && (tags_q[idx] == tag);

  // Fetches are always plain block reads.
  assign mem_o.req_valid = req_valid_q;
  assign mem_o.req_addr  = miss_addr_q;
  assign mem_o.req_size  = memsys_bus_pkg::SIZE_NONE;
  assign mem_o.req_wdata = '0;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q       <= memsys_bus_pkg::CACHE_READY;
      valid_q       <= '0;
      req_valid_q   <= 1'b0;
      fetch_valid_o <= 1'b0;
    end else begin
      // Both pulses last a single cycle.
      req_valid_q   <= 1'b0;
      fetch_valid_o <= 1'b0;
      case (state_q)
        memsys_bus_pkg::CACHE_READY: begin
          if (fetch_req_i) begin
            if (hit) begin
              fetch_valid_o <= 1'b1;
            end else begin
              req_valid_q <= 1'b1;
              state_q     <= memsys_bus_pkg::CACHE_REFILL;
            end
          end
        end
        default: begin
          if (mem_o.res_valid) begin
            valid_q[idx]  <= 1'b1;
            fetch_valid_o <= 1'b1;
            state_q       <= memsys_bus_pkg::CACHE_READY;
          end
        end
      endcase
    end
  end

  // Arrays and payload. A hit reads the cached block, a fill forwards the new one.
  always_ff @(posedge clk_i) begin
    if (state_q == memsys_bus_pkg::CACHE_READY && fetch_req_i) begin
      miss_addr_q   <= fetch_addr_i;
      fetch_instr_o <= blocks_q[idx][{fetch_addr_i[memsys_types_pkg::OFF_BITS-1:2], 5'b0} +: 32];
    end
    if (state_q == memsys_bus_pkg::CACHE_REFILL && mem_o.res_valid) begin
      blocks_q[idx] <= mem_o.res_blk;
      tags_q[idx]   <= tag;
      fetch_instr_o <= mem_o.res_blk[{miss_addr_q[memsys_types_pkg::OFF_BITS-1:2], 5'b0} +: 32];
    end
  end

endmodule

`default_nettype wire

/* hdl/iomem_if.sv */
/*
  Link between the memory arbiter and the block RAM.
  The request is held as a level until the single-cycle response.
*/
`default_nettype none

interface iomem_if;

  logic                      valid;
  memsys_types_pkg::addr_t   addr;
  memsys_types_pkg::blk_t    wdata;
  memsys_types_pkg::bmask_t  wmask;
  logic                      res_valid;
  memsys_types_pkg::blk_t    rdata;

  modport arbiter (output valid, addr, wdata, wmask, input res_valid, rdata);

  modport memory (input valid, addr, wdata, wmask, output res_valid, rdata);

endinterface

`default_nettype wire

/* hdl/cache_mem_if.sv */
/*
  Link between one cache and the memory arbiter.
  The cache pulses a request, the arbiter pulses the response with the block.
*/
`default_nettype none

interface cache_mem_if;

  logic                     req_valid;
  memsys_types_pkg::addr_t  req_addr;
  memsys_bus_pkg::size_e    req_size;
  // Store data already sits in its byte lane of the block.
  memsys_types_pkg::blk_t   req_wdata;
  logic                     res_valid;
  memsys_types_pkg::blk_t   res_blk;

  modport cache (
    output req_valid, req_addr, req_size, req_wdata,
    input  res_valid, res_blk
  );

  modport arbiter (
    input  req_valid, req_addr, req_size, req_wdata,
    output res_valid, res_blk
  );

endinterface

`default_nettype wire

/* hdl/memsys_bus_pkg.sv */
/*
  Bus and controller encodings of the memory subsystem.
  Access sizes, arbiter grant states and cache controller states.
*/
`default_nettype none

package memsys_bus_pkg;

  // Access size of a request. SIZE_NONE marks a plain block read.
  typedef enum logic [1:0] {
    SIZE_NONE,
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } size_e;

  // Which cache currently owns the memory port.
  typedef enum logic [1:0] {
    GRANT_IDLE,
    GRANT_ICACHE,
    GRANT_DCACHE
  } grant_e;

  // Both caches either serve from their arrays or wait on memory.
  typedef enum logic {
    CACHE_READY,
    CACHE_REFILL
  } cache_state_e;

endpackage

`default_nettype wire

/* hdl/memsys_types_pkg.sv */
/*
  Data types of the memory subsystem.
  Widths for addresses, words, blocks, byte masks and the cache address split.
*/
`default_nettype none
`include "memsys_config.svh"

package memsys_types_pkg;

  // Address split of a cache lookup: tag, line index, byte offset in the block.
  localparam int unsigned OFF_BITS = $clog2(`MEMSYS_BLK_BITS / 8);
  localparam int unsigned IDX_BITS = $clog2(`MEMSYS_LINES);
  localparam int unsigned TAG_BITS = 32 - IDX_BITS - OFF_BITS;

  typedef logic [31:0]                   addr_t;
  typedef logic [31:0]                   word_t;
  typedef logic [`MEMSYS_BLK_BITS-1:0]   blk_t;
  // One bit per byte of a block.
  typedef logic [`MEMSYS_BLK_BITS/8-1:0] bmask_t;
  typedef logic [IDX_BITS-1:0]           line_idx_t;
  typedef logic [TAG_BITS-1:0]           tag_t;

endpackage

`default_nettype wire

/* hdl/memsys_config.svh */
/*
  Memory subsystem configuration.
  Sets the cache geometry, the backing memory depth and the memory response latency.
*/
`ifndef MEMSYS_CONFIG_SVH
`define MEMSYS_CONFIG_SVH

// Number of lines in each direct-mapped cache.
`define MEMSYS_LINES 8

// Width of one cache block and one memory word, in bits.
`define MEMSYS_BLK_BITS 128

// Depth of the backing memory in blocks, which gives a 4 KiB address space.
`define MEMSYS_MEM_BLOCKS 256

// Cycles from an accepted memory request to its response pulse.
`define MEMSYS_MEM_LATENCY 3

`endif
